/* src/shadow_pipe_pkg.sv */
`default_nettype none

package shadow_pipe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [15:0] order_t;
    typedef logic [31:0] irq_vec_t;
    typedef logic [4:0]  irq_cause_t;

    // One retired instruction as reported by the reference model
    typedef struct packed {
        order_t    order;
        xlen_t     pc;
        xlen_t     insn;
        logic      csr_we;
        csr_addr_t csr_addr;
        xlen_t     csr_wdata;
        logic      is_mem;
    } retire_rec_t;

    // What travels from one stage to the next
    typedef struct packed {
        retire_rec_t rec;
        logic        valid;
    } pipe_slot_t;

    ////////////////////////////////////////////////////////////////////////////
    // CSRs and depths
    ////////////////////////////////////////////////////////////////////////////

    localparam csr_addr_t CSR_MSTATUS_ADDR = 12'h300;
    localparam csr_addr_t CSR_MIE_ADDR     = 12'h304;
    localparam int        MSTATUS_MIE_BIT  = 3;

    localparam int PIPE_DEPTH = 4;
    // Free steps needed to fill every stage in front of WB
    localparam int FILL_STEPS = PIPE_DEPTH - 1;
    localparam int LSU_DEPTH  = 2;

    typedef logic [$clog2(LSU_DEPTH + 1) - 1:0] lsu_cnt_t;

endpackage

`default_nettype wire

/* src/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    step_i,
    input  wire logic                    flush_i,
    input  shadow_pipe_pkg::pipe_slot_t  slot_i,
    output shadow_pipe_pkg::pipe_slot_t  slot_o
);

    import shadow_pipe_pkg::*;

    logic        valid_q;
    retire_rec_t rec_q;

    // Flush wins over step, a flushed slot never moves on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (step_i) begin
            valid_q <= slot_i.valid;
        end
    end

    // Record payload follows the same priority
    always_ff @(posedge clk) begin
        if (flush_i) begin
            rec_q <= '0;
        end else if (step_i) begin
            rec_q <= slot_i.rec;
        end
    end

    assign slot_o = '{rec: rec_q, valid: valid_q};

endmodule

`default_nettype wire

/* src/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    step_i,
    input  shadow_pipe_pkg::pipe_slot_t  slot_i,
    output logic                         valid_o,
    output shadow_pipe_pkg::retire_rec_t rec_o
);

    import shadow_pipe_pkg::*;

    logic        valid_q;
    retire_rec_t rec_q;

    // Valid only on the first cycle after the step, so a record
    // that sits in WB while the core stalls is reported once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (step_i) begin
            valid_q <= slot_i.valid;
        end else begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (step_i) begin
            rec_q <= slot_i.rec;
        end
    end

    assign valid_o = valid_q;
    assign rec_o   = rec_q;

endmodule

`default_nettype wire

/* src/step_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module step_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    core_retire_i,
    input  wire logic                    flush_i,
    input  shadow_pipe_pkg::pipe_slot_t  id_slot_i,
    input  shadow_pipe_pkg::pipe_slot_t  ex_slot_i,
    output logic                         step_o,
    output logic                         lsu_idle_o
);

    import shadow_pipe_pkg::*;

    logic [$clog2(FILL_STEPS + 1) - 1:0] fill_cnt_q;
    lsu_cnt_t                            lsu_cnt_q;
    logic                                lsu_up;
    logic                                lsu_down;

    // Free steps after reset or flush bring IF, ID and EX level with the core
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt_q <= '0;
        end else if (flush_i) begin
            fill_cnt_q <= '0;
        end else if (fill_cnt_q < FILL_STEPS) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
        end
    end

    assign step_o = (fill_cnt_q < FILL_STEPS) || core_retire_i;

    // A memory record counts as outstanding from EX until it moves on
    assign lsu_up   = step_o && id_slot_i.valid && id_slot_i.rec.is_mem;
    assign lsu_down = step_o && ex_slot_i.valid && ex_slot_i.rec.is_mem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsu_cnt_q <= '0;
        end else if (flush_i) begin
            lsu_cnt_q <= '0;
        end else if (lsu_up && !lsu_down && (lsu_cnt_q < LSU_DEPTH)) begin
            lsu_cnt_q <= lsu_cnt_q + 1'b1;
        end else if (lsu_down && !lsu_up && (lsu_cnt_q != '0)) begin
            lsu_cnt_q <= lsu_cnt_q - 1'b1;
        end
    end

    assign lsu_idle_o = (lsu_cnt_q == '0);

endmodule

`default_nettype wire

/* src/csr_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_tracker (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    step_i,
    input  wire logic                    flush_i,
    input  shadow_pipe_pkg::pipe_slot_t  ex_slot_i,
    output logic                         irq_en_o,
    output shadow_pipe_pkg::xlen_t       mie_mask_o
);

    import shadow_pipe_pkg::*;

    logic  csr_retire;
    logic  mstatus_wr;
    logic  mie_wr;
    logic  irq_en_q;
    xlen_t mie_mask_q;

    // The model writes CSRs at fetch, but the core only sees the effect
    // once the instruction reaches WB, so decode on the EX to WB move
    assign csr_retire = step_i && ex_slot_i.valid && ex_slot_i.rec.csr_we;
    assign mstatus_wr = csr_retire && (ex_slot_i.rec.csr_addr == CSR_MSTATUS_ADDR);
    assign mie_wr     = csr_retire && (ex_slot_i.rec.csr_addr == CSR_MIE_ADDR);

    ////////////////////////////////////////////////////////////////////////////
    // Global enable
    ////////////////////////////////////////////////////////////////////////////

    // The trap entry clears mstatus.MIE on the edge that ends the taken pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_en_q <= 1'b0;
        end else if (flush_i) begin
            irq_en_q <= 1'b0;
        end else if (mstatus_wr) begin
            irq_en_q <= ex_slot_i.rec.csr_wdata[MSTATUS_MIE_BIT];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-line mask
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_mask_q <= '0;
        end else if (mie_wr) begin
            mie_mask_q <= ex_slot_i.rec.csr_wdata;
        end
    end

    assign irq_en_o   = irq_en_q;
    assign mie_mask_o = mie_mask_q;

endmodule

`default_nettype wire

/* src/irq_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  shadow_pipe_pkg::irq_vec_t    irq_i,
    input  wire logic                    irq_allowed_i,
    input  wire logic                    irq_en_i,
    input  shadow_pipe_pkg::xlen_t       mie_mask_i,
    input  wire logic                    lsu_idle_i,
    output logic                         taken_o,
    output shadow_pipe_pkg::irq_cause_t  cause_o,
    output logic                         flush_o
);

    import shadow_pipe_pkg::*;

    irq_vec_t   irq_q;
    irq_vec_t   irq_qq;
    irq_vec_t   irq_pending;
    logic       take;
    logic       taken_q;
    irq_cause_t cause_q;

    // Lowest index wins
    function automatic irq_cause_t lowest_index(input irq_vec_t vec);
        irq_cause_t idx;
        idx = '0;
        for (int i = 31; i >= 0; i--) begin
            if (vec[i]) begin
                idx = irq_cause_t'(i);
            end
        end
        return idx;
    endfunction

    // Two stages of delay so the request lines up with the flushed pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q  <= '0;
            irq_qq <= '0;
        end else begin
            irq_q  <= irq_i;
            irq_qq <= irq_q;
        end
    end

    assign irq_pending = irq_qq & mie_mask_i;

    // The enable only drops on the flush edge, so hold off one cycle
    // after a take to keep the pulse single
    assign take = irq_en_i && (irq_pending != '0) && irq_allowed_i
                  && lsu_idle_i && !taken_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taken_q <= 1'b0;
            cause_q <= '0;
        end else begin
            taken_q <= take;
            if (take) begin
                cause_q <= lowest_index(irq_pending);
            end
        end
    end

    assign taken_o = taken_q;
    assign cause_o = cause_q;
    assign flush_o = taken_q;

endmodule

`default_nettype wire

/* src/shadow_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module shadow_pipe (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  shadow_pipe_pkg::retire_rec_t rec_i,
    input  wire logic                    core_retire_i,
    input  shadow_pipe_pkg::irq_vec_t    irq_i,
    input  wire logic                    irq_allowed_i,
    output logic                         step_o,
    output logic                         wb_valid_o,
    output shadow_pipe_pkg::retire_rec_t wb_rec_o,
    output logic                         irq_taken_o,
    output shadow_pipe_pkg::irq_cause_t  irq_cause_o
);

    import shadow_pipe_pkg::*;

    pipe_slot_t fetch_slot;
    pipe_slot_t if_slot;
    pipe_slot_t id_slot;
    pipe_slot_t ex_slot;
    logic       step;
    logic       flush;
    logic       irq_en;
    xlen_t      mie_mask;
    logic       lsu_idle;

    // Every record from the model is a real instruction
    assign fetch_slot = '{rec: rec_i, valid: 1'b1};

    ////////////////////////////////////////////////////////////////////////////
    // Record path
    ////////////////////////////////////////////////////////////////////////////

    pipe_stage if_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step),
        .flush_i (flush),
        .slot_i  (fetch_slot),
        .slot_o  (if_slot)
    );

    pipe_stage id_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step),
        .flush_i (flush),
        .slot_i  (if_slot),
        .slot_o  (id_slot)
    );

    pipe_stage ex_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step),
        .flush_i (flush),
        .slot_i  (id_slot),
        .slot_o  (ex_slot)
    );

    // No flush into WB, whatever already reached it still retires
    wb_stage wb_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step),
        .slot_i  (ex_slot),
        .valid_o (wb_valid_o),
        .rec_o   (wb_rec_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    step_ctrl step_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_retire_i (core_retire_i),
        .flush_i       (flush),
        .id_slot_i     (id_slot),
        .ex_slot_i     (ex_slot),
        .step_o        (step),
        .lsu_idle_o    (lsu_idle)
    );

    csr_tracker csr_tracker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_i     (step),
        .flush_i    (flush),
        .ex_slot_i  (ex_slot),
        .irq_en_o   (irq_en),
        .mie_mask_o (mie_mask)
    );

    irq_arbiter irq_arbiter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .irq_i         (irq_i),
        .irq_allowed_i (irq_allowed_i),
        .irq_en_i      (irq_en),
        .mie_mask_i    (mie_mask),
        .lsu_idle_i    (lsu_idle),
        .taken_o       (irq_taken_o),
        .cause_o       (irq_cause_o),
        .flush_o       (flush)
    );

    assign step_o = step;

endmodule

`default_nettype wire

/* testbench/shadow_pipe_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module shadow_pipe_checker (
    input  wire logic                    clk,
    input  wire logic                    check_en_i,
    input  wire logic                    done_i,
    input  wire logic [3:0]              test_id_i,
    input  wire logic                    step_i,
    input  wire logic                    wb_valid_i,
    input  shadow_pipe_pkg::retire_rec_t wb_rec_i,
    input  wire logic                    taken_i,
    input  shadow_pipe_pkg::irq_cause_t  cause_i,
    input  wire logic                    exp_step_i,
    input  wire logic                    exp_wb_valid_i,
    input  shadow_pipe_pkg::retire_rec_t exp_rec_i,
    input  wire logic                    exp_taken_i,
    input  shadow_pipe_pkg::irq_cause_t  exp_cause_i,
    output logic                         report_done_o,
    output int                           error_cnt_o
);

    import shadow_pipe_pkg::*;

    logic [3:0] cur_test      = '0;
    int         test_errors   = 0;
    int         test_checks   = 0;
    int         total_checks  = 0;
    int         total_tests   = 0;
    int         failed_tests  = 0;

    initial begin
        report_done_o = 1'b0;
        error_cnt_o   = 0;
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "fill_order";
            4'd2:    return "hold_no_retire";
            4'd3:    return "csr_enable";
            4'd4:    return "irq_blocked";
            4'd5:    return "irq_taken";
            4'd6:    return "flush_refill";
            4'd7:    return "lsu_block";
            default: return "unnamed";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] exp_val,
                                   input logic [127:0] act_val);
        $display("Mismatch in %s: %s expected %0h, actual %0h",
                 test_name(cur_test), what, exp_val, act_val);
        test_errors = test_errors + 1;
        error_cnt_o = error_cnt_o + 1;
    endtask

    // Closes the running test with its one-line summary
    task automatic close_test();
        if (cur_test != 4'd0) begin
            total_tests = total_tests + 1;
            if (test_errors == 0) begin
                $display("Test %s: ok, %0d cycles checked", test_name(cur_test), test_checks);
            end else begin
                failed_tests = failed_tests + 1;
                $display("Test %s: %0d errors in %0d cycles",
                         test_name(cur_test), test_errors, test_checks);
            end
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle comparison
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (check_en_i) begin
            if (test_id_i != cur_test) begin
                close_test();
                cur_test = test_id_i;
            end
            test_checks  = test_checks + 1;
            total_checks = total_checks + 1;
            if (step_i !== exp_step_i)
                report_mismatch("step_o", 128'(exp_step_i), 128'(step_i));
            if (wb_valid_i !== exp_wb_valid_i)
                report_mismatch("wb_valid_o", 128'(exp_wb_valid_i), 128'(wb_valid_i));
            // The record is only meaningful while it is being retired
            if (exp_wb_valid_i && (wb_rec_i !== exp_rec_i))
                report_mismatch("wb_rec_o", 128'(exp_rec_i), 128'(wb_rec_i));
            if (taken_i !== exp_taken_i)
                report_mismatch("irq_taken_o", 128'(exp_taken_i), 128'(taken_i));
            if (exp_taken_i && (cause_i !== exp_cause_i))
                report_mismatch("irq_cause_o", 128'(exp_cause_i), 128'(cause_i));
        end else if (done_i && !report_done_o) begin
            close_test();
            $display("Tests: %0d, failed: %0d, cycles checked: %0d, errors: %0d",
                     total_tests, failed_tests, total_checks, error_cnt_o);
            report_done_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* testbench/shadow_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module shadow_pipe_tb;

    import shadow_pipe_pkg::*;

    localparam int MAX_PATTERNS = 128;
    localparam int FIELDS       = 14;
    localparam int RESET_CYCLES = 5;

    logic        clk;
    logic        rst_n;
    retire_rec_t rec;
    logic        core_retire;
    irq_vec_t    irq;
    logic        irq_allowed;
    logic        step;
    logic        wb_valid;
    retire_rec_t wb_rec;
    logic        irq_taken;
    irq_cause_t  irq_cause;

    logic        check_en;
    logic        run_done;
    logic [3:0]  test_id;
    logic        exp_step;
    logic        exp_wb_valid;
    retire_rec_t exp_rec;
    logic        exp_taken;
    irq_cause_t  exp_cause;
    logic        report_done;
    int          error_cnt;

    int          pat [MAX_PATTERNS][FIELDS];
    int          n_patterns;
    retire_rec_t rec_tab [256];
    bit          rec_seen [256];
    logic [31:0] lfsr;
    int          cycle_cnt;
    int          cycle_limit;

    shadow_pipe dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rec_i         (rec),
        .core_retire_i (core_retire),
        .irq_i         (irq),
        .irq_allowed_i (irq_allowed),
        .step_o        (step),
        .wb_valid_o    (wb_valid),
        .wb_rec_o      (wb_rec),
        .irq_taken_o   (irq_taken),
        .irq_cause_o   (irq_cause)
    );

    shadow_pipe_checker monitor_i (
        .clk            (clk),
        .check_en_i     (check_en),
        .done_i         (run_done),
        .test_id_i      (test_id),
        .step_i         (step),
        .wb_valid_i     (wb_valid),
        .wb_rec_i       (wb_rec),
        .taken_i        (irq_taken),
        .cause_i        (irq_cause),
        .exp_step_i     (exp_step),
        .exp_wb_valid_i (exp_wb_valid),
        .exp_rec_i      (exp_rec),
        .exp_taken_i    (exp_taken),
        .exp_cause_i    (exp_cause),
        .report_done_o  (report_done),
        .error_cnt_o    (error_cnt)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random record contents
    ////////////////////////////////////////////////////////////////////////////

    // Galois form with one shift per bit handed out
    function automatic logic next_random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    task automatic random_word(output xlen_t w);
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], next_random_bit()};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Pattern file
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_patterns();
        int    fd;
        int    cnt;
        int    f [FIELDS];
        string line;
        n_patterns = 0;
        fd = $fopen("testbench/shadow_pipe_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file");
        end else begin
            while (!$feof(fd) && n_patterns < MAX_PATTERNS) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                  f[8], f[9], f[10], f[11], f[12], f[13]);
                    if (cnt == FIELDS) begin
                        for (int k = 0; k < FIELDS; k++)
                            pat[n_patterns][k] = f[k];
                        n_patterns = n_patterns + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // A record is built once per order number so a held record keeps its value
    task automatic record_for(input int idx, output retire_rec_t r);
        int    ord;
        xlen_t w;
        ord = pat[idx][4] & 255;
        if (!rec_seen[ord]) begin
            rec_tab[ord].order     = order_t'(ord);
            random_word(w);
            rec_tab[ord].pc        = w;
            random_word(w);
            rec_tab[ord].insn      = w;
            rec_tab[ord].csr_we    = pat[idx][5][0];
            rec_tab[ord].csr_addr  = csr_addr_t'(pat[idx][6]);
            rec_tab[ord].csr_wdata = xlen_t'(pat[idx][7]);
            rec_tab[ord].is_mem    = pat[idx][8][0];
            rec_seen[ord]          = 1'b1;
        end
        r = rec_tab[ord];
    endtask

    task automatic apply_pattern(input int idx);
        retire_rec_t r;
        record_for(idx, r);
        rec          = r;
        test_id      = 4'(pat[idx][0]);
        core_retire  = pat[idx][1][0];
        irq          = irq_vec_t'(pat[idx][2]);
        irq_allowed  = pat[idx][3][0];
        exp_step     = pat[idx][9][0];
        exp_wb_valid = pat[idx][10][0];
        exp_rec      = rec_tab[pat[idx][11] & 255];
        exp_taken    = pat[idx][12][0];
        exp_cause    = irq_cause_t'(pat[idx][13]);
        check_en     = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        rec          = '0;
        core_retire  = 1'b0;
        irq          = '0;
        irq_allowed  = 1'b0;
        check_en     = 1'b0;
        run_done     = 1'b0;
        test_id      = '0;
        exp_step     = 1'b0;
        exp_wb_valid = 1'b0;
        exp_rec      = '0;
        exp_taken    = 1'b0;
        exp_cause    = '0;
        cycle_cnt    = 0;
        cycle_limit  = 1000;
        lfsr         = 32'h0ccf_1626;
        load_patterns();
        cycle_limit = n_patterns + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_patterns; i++) begin
            if (i > 0)
                @(negedge clk);
            apply_pattern(i);
        end
        @(negedge clk);
        check_en = 1'b0;
        run_done = 1'b1;
        wait (report_done);

        if (error_cnt == 0 && n_patterns > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Run length is known once the patterns are loaded
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* shadow_pipe.f */
src/shadow_pipe_pkg.sv
src/pipe_stage.sv
src/wb_stage.sv
src/step_ctrl.sv
src/csr_tracker.sv
src/irq_arbiter.sv
src/shadow_pipe.sv
testbench/shadow_pipe_checker.sv
testbench/shadow_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the shadow pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module shadow_pipe_tb \
    --Mdir obj_dir \
    -o sim_shadow_pipe \
    -f shadow_pipe.f

./obj_dir/sim_shadow_pipe > sim.log 2>&1 || true
cat sim.log

if grep -F -q '*** PASSED ***' sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

/* testbench/shadow_pipe_patterns.txt */
# test retire irq allowed order csr_we csr_addr csr_wdata is_mem (all hex)
# then expected: step wb_valid wb_order irq_taken irq_cause
1 0 0 1 1  0 000 0 0  1 0 0  0 0
1 0 0 1 2  0 000 0 0  1 0 0  0 0
1 0 0 1 3  0 000 0 0  1 0 0  0 0
1 1 0 1 4  0 000 0 0  1 0 0  0 0
1 1 0 1 5  0 000 0 0  1 1 1  0 0
1 1 0 1 6  0 000 0 0  1 1 2  0 0
2 0 0 1 7  0 000 0 0  0 1 3  0 0
2 0 0 1 7  0 000 0 0  0 0 0  0 0
2 0 0 1 7  0 000 0 0  0 0 0  0 0
2 1 0 1 7  0 000 0 0  1 0 0  0 0
2 0 0 1 8  1 300 8 0  0 1 4  0 0
3 1 2 1 8  1 300 8 0  1 0 0  0 0
3 1 2 1 9  1 304 a 0  1 1 5  0 0
3 1 2 1 a  0 000 0 0  1 1 6  0 0
3 1 0 1 b  0 000 0 0  1 1 7  0 0
3 1 0 1 c  0 000 0 0  1 1 8  0 0
4 0 4 1 d  0 000 0 0  0 1 9  0 0
4 0 8 0 d  0 000 0 0  0 0 0  0 0
4 0 0 0 d  0 000 0 0  0 0 0  0 0
4 0 0 0 d  0 000 0 0  0 0 0  0 0
4 0 0 1 d  0 000 0 0  0 0 0  0 0
5 0 e 1 d  0 000 0 0  0 0 0  0 0
5 0 e 1 d  0 000 0 0  0 0 0  0 0
5 0 0 1 d  0 000 0 0  0 0 0  0 0
5 0 0 1 d  0 000 0 0  0 0 0  1 1
6 0 0 1 d  0 000 0 0  1 0 0  0 0
6 0 0 1 e  0 000 0 0  1 0 0  0 0
6 0 0 1 f  0 000 0 0  1 0 0  0 0
6 1 2 1 10 0 000 0 0  1 0 0  0 0
6 1 2 1 11 0 000 0 0  1 1 d  0 0
6 1 0 1 12 0 000 0 0  1 1 e  0 0
6 1 0 1 13 1 300 8 0  1 1 f  0 0
7 1 0 1 14 0 000 0 1  1 1 10 0 0
7 1 0 1 15 0 000 0 0  1 1 11 0 0
7 1 0 1 16 0 000 0 0  1 1 12 0 0
7 0 8 1 17 0 000 0 0  0 1 13 0 0
7 0 8 1 17 0 000 0 0  0 0 0  0 0
7 0 8 1 17 0 000 0 0  0 0 0  0 0
7 1 8 1 17 0 000 0 0  1 0 0  0 0
7 0 0 1 18 0 000 0 0  0 1 14 0 0
7 0 0 1 18 0 000 0 0  0 0 0  1 3
7 0 0 1 18 0 000 0 0  1 0 0  0 0
